//--- include/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data and pc width
`define CORE_XLEN 32

// architectural registers, r0 reads as zero
`define CORE_REGS 16

// queue slots, power of two, one slot always left free
`define IQ_DEPTH 8

`endif

//--- hw/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

    typedef logic [$clog2(`CORE_REGS)-1:0] reg_idx_t;

    // opcode lives in instr[31:28]
    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_add  = 4'd1,
        op_sub  = 4'd2,
        op_and  = 4'd3,
        op_or   = 4'd4,
        op_xor  = 4'd5,
        op_addi = 4'd6,
        op_beq  = 4'd7
    } opcode_e;

    typedef enum logic [1:0] {
        idle,
        wait_mem,
        hold_word
    } fetch_state_e;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [31:0]           instr;
    } iq_entry_t;

    typedef struct packed {
        logic                  valid;
        opcode_e               op;
        reg_idx_t              rd;
        reg_idx_t              rs1;
        reg_idx_t              rs2;
        logic [`CORE_XLEN-1:0] imm;
        logic [`CORE_XLEN-1:0] pc;
    } dec_op_t;

    typedef struct packed {
        logic                  valid;
        logic                  writes;
        reg_idx_t              rd;
        logic [`CORE_XLEN-1:0] data;
        logic [`CORE_XLEN-1:0] pc;
        logic                  taken;
        logic [`CORE_XLEN-1:0] target;
    } exe_result_t;

endpackage

//--- hw/fetch_unit.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  arst_n,
    output logic                  mem_req,
    output logic [`CORE_XLEN-1:0] mem_pc,
    input  logic                  mem_done,
    input  logic [31:0]           mem_instr,
    output logic                  word_valid,
    output core_pkg::iq_entry_t   word,
    input  logic                  accept,
    input  logic                  flush,
    input  logic [`CORE_XLEN-1:0] redirect_pc
);

    core_pkg::fetch_state_e state;
    logic [`CORE_XLEN-1:0]  pc;
    // reply in flight belongs to the old stream
    logic                   stale;

    assign mem_pc     = pc;
    assign word_valid = (state == core_pkg::hold_word);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= core_pkg::idle;
            pc      <= '0;
            stale   <= 1'b0;
            mem_req <= 1'b0;
        end else if (flush) begin
            pc <= redirect_pc;
            if ((state == core_pkg::wait_mem && !mem_done) || mem_req) begin
                stale   <= 1'b1;
                state   <= core_pkg::wait_mem;
                mem_req <= 1'b0;
            end else begin
                stale   <= 1'b0;
                state   <= core_pkg::idle;
                mem_req <= 1'b1;
            end
        end else begin
            mem_req <= 1'b0;
            case (state)
                core_pkg::idle: begin
                    if (mem_req) begin
                        state <= core_pkg::wait_mem;
                    end else begin
                        mem_req <= 1'b1;
                    end
                end
                core_pkg::wait_mem: begin
                    if (mem_done && stale) begin
                        // drop it and ask again at the redirected pc
                        stale   <= 1'b0;
                        state   <= core_pkg::idle;
                        mem_req <= 1'b1;
                    end else if (mem_done) begin
                        state <= core_pkg::hold_word;
                    end
                end
                core_pkg::hold_word: begin
                    if (accept) begin
                        pc      <= pc + `CORE_XLEN'(4);
                        state   <= core_pkg::idle;
                        mem_req <= 1'b1;
                    end
                end
                default: state <= core_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == core_pkg::wait_mem && mem_done) begin
            word <= '{pc: pc, instr: mem_instr};
        end
    end

    // a request always leads into wait_mem, never out of it
    a_one_outstanding: assert property (@(posedge clk) disable iff (!arst_n)
        mem_req |-> state != core_pkg::wait_mem ##1 state == core_pkg::wait_mem);

endmodule

//--- hw/instr_queue.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module instr_queue (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                word_valid,
    input  core_pkg::iq_entry_t word,
    output logic                accept,
    input  logic                hold,
    output logic                issue_valid,
    output core_pkg::iq_entry_t issue_entry,
    input  logic                flush
);

    localparam int idx_w = $clog2(`IQ_DEPTH);

    core_pkg::iq_entry_t slots [`IQ_DEPTH];

    // one extra bit over the slot index
    logic [idx_w:0] head;
    logic [idx_w:0] tail;
    logic [idx_w:0] used;
    logic           empty;
    logic           full;
    logic           can_issue;

    assign used      = tail - head;
    assign empty     = (head == tail);
    assign full      = (used == `IQ_DEPTH - 1);
    assign can_issue = !empty && !hold;

    // store strobe back to fetch
    assign accept = word_valid && !full && !flush;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head        <= '0;
            tail        <= '0;
            issue_valid <= 1'b0;
        end else if (flush) begin
            head        <= '0;
            tail        <= '0;
            issue_valid <= 1'b0;
        end else begin
            if (accept) begin
                tail <= tail + 1'b1;
            end
            if (can_issue) begin
                head <= head + 1'b1;
            end
            issue_valid <= can_issue;
        end
    end

    // write and read never hit the same slot in one cycle
    always_ff @(posedge clk) begin
        if (accept) begin
            slots[tail[idx_w-1:0]] <= word;
        end
        if (can_issue) begin
            issue_entry <= slots[head[idx_w-1:0]];
        end
    end

    // occupancy never reaches the slot count
    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        used < `IQ_DEPTH);

endmodule

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module decode_stage (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                issue_valid,
    input  core_pkg::iq_entry_t issue_entry,
    input  logic                flush,
    output core_pkg::dec_op_t   dec
);

    core_pkg::dec_op_t nxt;

    always_comb begin
        nxt       = '0;
        nxt.valid = issue_valid;
        nxt.rd    = issue_entry.instr[27:24];
        nxt.rs1   = issue_entry.instr[23:20];
        nxt.rs2   = issue_entry.instr[19:16];
        nxt.imm   = {{(`CORE_XLEN-16){issue_entry.instr[15]}}, issue_entry.instr[15:0]};
        nxt.pc    = issue_entry.pc;
        // unknown codes fall back to nop
        nxt.op    = core_pkg::op_nop;
        case (issue_entry.instr[31:28])
            core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and,
            core_pkg::op_or, core_pkg::op_xor, core_pkg::op_addi,
            core_pkg::op_beq: begin
                nxt.op = core_pkg::opcode_e'(issue_entry.instr[31:28]);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec <= '0;
        end else begin
            dec <= nxt;
            if (flush) begin
                dec.valid <= 1'b0;
            end
        end
    end

endmodule

//--- hw/execute_stage.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module execute_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  core_pkg::dec_op_t     dec,
    output core_pkg::reg_idx_t    rf_raddr_a,
    output core_pkg::reg_idx_t    rf_raddr_b,
    input  logic [`CORE_XLEN-1:0] rf_rdata_a,
    input  logic [`CORE_XLEN-1:0] rf_rdata_b,
    input  core_pkg::exe_result_t res,
    input  logic                  flush,
    output core_pkg::exe_result_t exe
);

    logic [`CORE_XLEN-1:0] opa;
    logic [`CORE_XLEN-1:0] opb;
    core_pkg::exe_result_t nxt;

    assign rf_raddr_a = dec.rs1;
    assign rf_raddr_b = dec.rs2;

    // bypass from the op one stage ahead, writes implies rd != 0
    assign opa = (res.valid && res.writes && res.rd == dec.rs1) ? res.data : rf_rdata_a;
    assign opb = (res.valid && res.writes && res.rd == dec.rs2) ? res.data : rf_rdata_b;

    always_comb begin
        nxt        = '0;
        nxt.valid  = dec.valid;
        nxt.rd     = dec.rd;
        nxt.pc     = dec.pc;
        nxt.target = dec.pc + (dec.imm << 2);
        case (dec.op)
            core_pkg::op_add:  nxt.data = opa + opb;
            core_pkg::op_sub:  nxt.data = opa - opb;
            core_pkg::op_and:  nxt.data = opa & opb;
            core_pkg::op_or:   nxt.data = opa | opb;
            core_pkg::op_xor:  nxt.data = opa ^ opb;
            core_pkg::op_addi: nxt.data = opa + dec.imm;
            core_pkg::op_beq:  nxt.taken = (opa == opb);
            default: ;
        endcase
        nxt.writes = (dec.op != core_pkg::op_nop) && (dec.op != core_pkg::op_beq) &&
                     (dec.rd != '0);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exe <= '0;
        end else begin
            exe <= nxt;
            if (flush) begin
                exe.valid <= 1'b0;
            end
        end
    end

endmodule

//--- hw/result_stage.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module result_stage (
    input  logic                  clk,
    input  logic                  arst_n,
    input  core_pkg::exe_result_t exe,
    input  core_pkg::reg_idx_t    rf_raddr_a,
    input  core_pkg::reg_idx_t    rf_raddr_b,
    output logic [`CORE_XLEN-1:0] rf_rdata_a,
    output logic [`CORE_XLEN-1:0] rf_rdata_b,
    output logic                  flush,
    output logic [`CORE_XLEN-1:0] redirect_pc,
    output logic                  wb_valid,
    output core_pkg::reg_idx_t    wb_rd,
    output logic [`CORE_XLEN-1:0] wb_data,
    output logic [`CORE_XLEN-1:0] wb_pc
);

    logic [`CORE_XLEN-1:0] rf [`CORE_REGS];

    // r0 is never written and reads as zero
    assign rf_rdata_a = (rf_raddr_a == '0) ? '0 : rf[rf_raddr_a];
    assign rf_rdata_b = (rf_raddr_b == '0) ? '0 : rf[rf_raddr_b];

    // taken beq kills everything younger
    assign flush       = exe.valid && exe.taken;
    assign redirect_pc = exe.target;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= exe.valid && exe.writes;
        end
    end

    always_ff @(posedge clk) begin
        if (exe.valid && exe.writes) begin
            rf[exe.rd] <= exe.data;
        end
        wb_rd   <= exe.rd;
        wb_data <= exe.data;
        wb_pc   <= exe.pc;
    end

    // the branch writes nothing back and the op behind it is killed
    a_flush_kills: assert property (@(posedge clk) disable iff (!arst_n)
        flush |=> !exe.valid && !wb_valid);

endmodule

//--- hw/core_top.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core_top (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  hold,
    input  logic                  mem_done,
    input  logic [31:0]           mem_instr,
    output logic                  mem_req,
    output logic [`CORE_XLEN-1:0] mem_pc,
    output logic                  wb_valid,
    output core_pkg::reg_idx_t    wb_rd,
    output logic [`CORE_XLEN-1:0] wb_data,
    output logic [`CORE_XLEN-1:0] wb_pc
);

    logic                  word_valid;
    core_pkg::iq_entry_t   word;
    logic                  accept;
    logic                  issue_valid;
    core_pkg::iq_entry_t   issue_entry;
    logic                  flush;
    logic [`CORE_XLEN-1:0] redirect_pc;
    core_pkg::dec_op_t     dec;
    core_pkg::exe_result_t exe;
    core_pkg::reg_idx_t    rf_raddr_a;
    core_pkg::reg_idx_t    rf_raddr_b;
    logic [`CORE_XLEN-1:0] rf_rdata_a;
    logic [`CORE_XLEN-1:0] rf_rdata_b;

    fetch_unit u_fetch (.clk, .arst_n, .mem_req, .mem_pc, .mem_done, .mem_instr,
                        .word_valid, .word, .accept, .flush, .redirect_pc);

    instr_queue u_queue (.clk, .arst_n, .word_valid, .word, .accept, .hold,
                         .issue_valid, .issue_entry, .flush);

    decode_stage u_decode (.clk, .arst_n, .issue_valid, .issue_entry, .flush, .dec);

    // execute sees its own result register for bypass
    execute_stage u_execute (.clk, .arst_n, .dec, .rf_raddr_a, .rf_raddr_b,
                             .rf_rdata_a, .rf_rdata_b, .res(exe), .flush, .exe);

    result_stage u_result (.clk, .arst_n, .exe, .rf_raddr_a, .rf_raddr_b, .rf_rdata_a,
                           .rf_rdata_b, .flush, .redirect_pc, .wb_valid, .wb_rd,
                           .wb_data, .wb_pc);

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter real half_period = 2.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

//--- test/tb_core.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_core;

    typedef struct packed {
        logic [3:0]            rd;
        logic [`CORE_XLEN-1:0] data;
        logic [`CORE_XLEN-1:0] pc;
    } wb_entry_t;

    // words over all five programs
    localparam int words_total = 12 + 6 + 12 + 14 + 32;
    localparam int cycles_per_word = 40;

    logic                  clk;
    logic                  arst_n;
    logic                  hold;
    logic                  mem_done;
    logic [31:0]           mem_instr;
    logic                  mem_req;
    logic [`CORE_XLEN-1:0] mem_pc;
    logic                  wb_valid;
    logic [3:0]            wb_rd;
    logic [`CORE_XLEN-1:0] wb_data;
    logic [`CORE_XLEN-1:0] wb_pc;

    logic [31:0]           prog [64];
    logic [`CORE_XLEN-1:0] model_rf [`CORE_REGS];
    wb_entry_t             exp_q [$];
    int                    prog_len = 0;
    int                    got_count = 0;
    int                    req_count = 0;
    int                    mismatches = 0;
    int                    missing = 0;
    int                    extra = 0;
    int                    max_delay = 4;
    integer                seed = 32'hda65;

    tb_clock u_clock (.clk);

    core_top uut (.clk, .arst_n, .hold, .mem_done, .mem_instr, .mem_req, .mem_pc,
                  .wb_valid, .wb_rd, .wb_data, .wb_pc);

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at time %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic emit(input int op, input int rd, input int rs1, input int rs2, input int imm);
        prog[prog_len] = {4'(op), 4'(rd), 4'(rs1), 4'(rs2), 16'(imm)};
        prog_len++;
    endtask

    // executes the loaded program and lists the writebacks it must produce
    task automatic run_model();
        logic [31:0]           w;
        logic [`CORE_XLEN-1:0] a;
        logic [`CORE_XLEN-1:0] b;
        logic [`CORE_XLEN-1:0] imm;
        logic [`CORE_XLEN-1:0] pc;
        logic                  writes;
        wb_entry_t             e;
        int                    steps;
        pc = '0;
        steps = 0;
        exp_q.delete();
        while ((pc >> 2) < prog_len && steps < 1000) begin
            w      = prog[pc[7:2]];
            a      = model_rf[w[23:20]];
            b      = model_rf[w[19:16]];
            imm    = {{(`CORE_XLEN-16){w[15]}}, w[15:0]};
            writes = 1'b1;
            e.rd   = w[27:24];
            e.pc   = pc;
            e.data = '0;
            case (w[31:28])
                core_pkg::op_add:  e.data = a + b;
                core_pkg::op_sub:  e.data = a - b;
                core_pkg::op_and:  e.data = a & b;
                core_pkg::op_or:   e.data = a | b;
                core_pkg::op_xor:  e.data = a ^ b;
                core_pkg::op_addi: e.data = a + imm;
                default: writes = 1'b0;
            endcase
            if (writes && e.rd != 4'd0) begin
                model_rf[e.rd] = e.data;
                exp_q.push_back(e);
            end
            if (w[31:28] == core_pkg::op_beq && a == b) begin
                pc = pc + (imm << 2);
            end else begin
                pc = pc + 4;
            end
            steps++;
        end
    endtask

    task automatic begin_test(input int delay);
        @(posedge clk);
        arst_n <= 1'b0;
        hold   <= 1'b0;
        max_delay = delay;
        prog_len = 0;
    endtask

    task automatic release_reset();
        run_model();
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
    endtask

    task automatic wait_count(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (got_count < n && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
    endtask

    task automatic finish_test(input string name, input int words);
        wait_count(exp_q.size(), cycles_per_word * words);
        if (got_count < exp_q.size()) begin
            missing += exp_q.size() - got_count;
            $display("%s test: %0d of %0d writebacks never arrived", name,
                     exp_q.size() - got_count, exp_q.size());
        end
        // time for late extra writebacks to show
        repeat (20) @(posedge clk);
    endtask

    task automatic test_alu();
        begin_test(4);
        emit(core_pkg::op_addi, 1, 0, 0, 16'h1234);
        emit(core_pkg::op_addi, 2, 0, 0, -7);
        emit(core_pkg::op_addi, 5, 0, 0, 16'h0f0f);
        emit(core_pkg::op_addi, 6, 0, 0, 16'h00ff);
        emit(core_pkg::op_add, 3, 1, 2, 0);
        emit(core_pkg::op_sub, 4, 1, 2, 0);
        emit(core_pkg::op_and, 7, 5, 6, 0);
        emit(core_pkg::op_or, 8, 5, 6, 0);
        emit(core_pkg::op_xor, 9, 5, 6, 0);
        // r0 targets and an unknown opcode
        emit(core_pkg::op_addi, 0, 1, 0, 5);
        emit(core_pkg::op_add, 0, 1, 2, 0);
        emit(15, 10, 1, 2, 0);
        release_reset();
        finish_test("alu", 12);
    endtask

    task automatic test_forward();
        begin_test(4);
        emit(core_pkg::op_addi, 1, 0, 0, 1);
        emit(core_pkg::op_addi, 1, 1, 0, 2);
        emit(core_pkg::op_add, 2, 1, 1, 0);
        emit(core_pkg::op_sub, 3, 2, 1, 0);
        emit(core_pkg::op_xor, 4, 3, 2, 0);
        emit(core_pkg::op_add, 4, 4, 4, 0);
        release_reset();
        finish_test("forward", 6);
    endtask

    task automatic test_hold();
        int wb_before;
        int req_before;
        begin_test(4);
        for (int i = 1; i <= 12; i++) begin
            emit(1 + i % 6, i, i - 1, i / 2, i * 7);
        end
        release_reset();
        wait_count(2, cycles_per_word * 12);
        hold <= 1'b1;
        // decode, execute and result drain first
        repeat (10) @(posedge clk);
        wb_before = got_count;
        repeat (60) @(posedge clk);
        req_before = req_count;
        repeat (20) @(posedge clk);
        check_value("writebacks during hold", got_count, wb_before);
        check_value("mem_req with queue full", req_count, req_before);
        hold <= 1'b0;
        finish_test("hold", 12);
    endtask

    task automatic test_branch();
        begin_test(4);
        emit(core_pkg::op_addi, 1, 0, 0, 5);
        emit(core_pkg::op_addi, 2, 0, 0, 5);
        emit(core_pkg::op_beq, 0, 1, 2, 3);
        emit(core_pkg::op_addi, 3, 0, 0, 1);
        emit(core_pkg::op_addi, 4, 0, 0, 2);
        emit(core_pkg::op_addi, 5, 0, 0, 3);
        emit(core_pkg::op_beq, 0, 1, 5, 2);
        emit(core_pkg::op_addi, 6, 0, 0, 4);
        // two-pass loop closed by a backward branch
        emit(core_pkg::op_addi, 7, 0, 0, 2);
        emit(core_pkg::op_add, 8, 7, 7, 0);
        emit(core_pkg::op_addi, 7, 7, 0, -1);
        emit(core_pkg::op_beq, 0, 7, 0, 2);
        emit(core_pkg::op_beq, 0, 0, 0, -3);
        emit(core_pkg::op_addi, 9, 0, 0, 7);
        release_reset();
        finish_test("branch", 14);
    endtask

    task automatic test_long();
        begin_test(10);
        for (int i = 10; i < 16; i++) begin
            emit(core_pkg::op_addi, i, 0, 0, i * 37);
        end
        for (int i = 6; i < 32; i++) begin
            emit(1 + $unsigned($random(seed)) % 6, $random(seed), $random(seed),
                 $random(seed), $random(seed));
        end
        release_reset();
        hold <= 1'b1;
        repeat (100) @(posedge clk);
        check_value("writebacks behind hold", got_count, 0);
        hold <= 1'b0;
        finish_test("long program", 32);
    endtask

    // instruction memory, one request at a time
    initial begin
        int                    delay;
        logic [`CORE_XLEN-1:0] addr;
        mem_done  <= 1'b0;
        mem_instr <= '0;
        forever begin
            @(posedge clk);
            mem_done <= 1'b0;
            if (arst_n && mem_req) begin
                addr  = mem_pc;
                delay = 1 + int'($unsigned($random(seed)) % max_delay);
                for (int i = 0; i < delay && arst_n; i++) begin
                    @(posedge clk);
                end
                if (arst_n) begin
                    mem_done  <= 1'b1;
                    mem_instr <= ((addr >> 2) < prog_len) ? prog[addr[7:2]] : 32'h0;
                end
            end
        end
    end

    always @(negedge clk) begin
        if (!arst_n) begin
            got_count = 0;
        end else begin
            if (mem_req) begin
                req_count++;
            end
            if (wb_valid) begin
                if (got_count < exp_q.size()) begin
                    check_value("wb_rd", 32'(wb_rd), 32'(exp_q[got_count].rd));
                    check_value("wb_data", wb_data, exp_q[got_count].data);
                    check_value("wb_pc", wb_pc, exp_q[got_count].pc);
                end else begin
                    extra++;
                    $display("unexpected extra writeback to r%0d at time %0t", wb_rd, $time);
                end
                got_count++;
            end
        end
    end

    initial begin
        repeat (cycles_per_word * words_total) @(posedge clk);
        $display("timeout: tests still running after %0d cycles",
                 cycles_per_word * words_total);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        arst_n <= 1'b0;
        hold   <= 1'b0;
        foreach (model_rf[i]) begin
            model_rf[i] = '0;
        end
        test_alu();
        test_forward();
        test_hold();
        test_branch();
        test_long();
        $display("errors: %0d mismatches, %0d missing writebacks, %0d extra writebacks",
                 mismatches, missing, extra);
        if (mismatches + missing + extra == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+include
hw/core_pkg.sv
hw/fetch_unit.sv
hw/instr_queue.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/result_stage.sv
hw/core_top.sv
test/tb_clock.sv
test/tb_core.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module tb_core \
    > build.log 2>&1 \
    && ./obj_dir/Vtb_core > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
grep -q "Result: FAILED" sim.log && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
